/* rtl/telemetry_pkg.sv */
// control side definitions of the weather telemetry transmitter
// channel type, channel count and header frame constants
// state encodings of the sequencer, frame scheduler and link controller
package telemetry_pkg;

	// converter channel number, one of eight mux inputs
	typedef logic [2:0] chan_t;

	// channel counter wraps after the last mux input
	localparam int NUM_CHANNELS = 8;

	// marks a header byte, followed by a zero bit and the channel
	localparam logic [3:0] HDR_MARK = 4'hA;

	// converter sequencer
	typedef enum logic [2:0] {
		acq_idle,
		acq_select,
		acq_start_conv,
		acq_wait_eoc,
		acq_wait_release,
		acq_request,
		acq_wait_ack
	} acq_state_t;

	// two frames per sample
	typedef enum logic [2:0] {
		sched_idle,
		sched_header,
		sched_wait_header,
		sched_data,
		sched_wait_data,
		sched_release
	} sched_state_t;

	// one pass per frame
	typedef enum logic [1:0] {
		link_idle,
		link_load,
		link_send,
		link_wait_end
	} link_state_t;

endpackage

/* rtl/serial_pkg.sv */
// serial line definitions
// bit timing and the bit slot sequence of one frame
package serial_pkg;

	// clocks per serial bit
	localparam int BIT_CYCLES = 16;
	localparam int BIT_CNT_W  = $clog2(BIT_CYCLES);

	// start bit, eight data bits, stop bit
	localparam int FRAME_BITS = 10;

	// slot currently driven on the line, msb first
	typedef enum logic [$clog2(FRAME_BITS)-1:0] {
		slot_start,
		slot_bit7,
		slot_bit6,
		slot_bit5,
		slot_bit4,
		slot_bit3,
		slot_bit2,
		slot_bit1,
		slot_bit0,
		slot_stop
	} bit_slot_t;

endpackage

/* rtl/tx_ctrl_if.sv */
// control bundle between the link controller and the transmit data path
// ctrl and path modports
`timescale 1ns/100ps

interface tx_ctrl_if;
	// strobes and frame byte from the link controller
	logic       load;
	logic       send;
	logic [7:0] frame_byte;
	// status back from the data path
	logic       tx_end;
	logic       busy;
	logic       error;

	modport ctrl (
		output load, send, frame_byte,
		input  tx_end, busy, error
	);

	modport path (
		input  load, send, frame_byte,
		output tx_end, busy, error
	);
endinterface

/* rtl/acq_sequencer.sv */
// converter sequencer
// drives the mux and the soc/eoc handshake, captures each sample
// and hands it to the frame scheduler over send_data/rdy
`timescale 1ns/100ps

module acq_sequencer import telemetry_pkg::*; (
	input  logic       clock,
	input  logic       rst,
	input  logic       eoc,
	input  logic [7:0] data_in,
	output logic       soc,
	output logic       load_dato,
	output logic       mux_en,
	output chan_t      canale,
	output logic       send_data,
	input  logic       rdy,
	output logic [7:0] sample
);

	acq_state_t state;

	// sample byte, held stable while send_data is high
	always_ff @(posedge clock) begin
		if (state == acq_wait_eoc && eoc) begin
			sample <= data_in;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			state     <= acq_idle;
			soc       <= 1'b0;
			load_dato <= 1'b0;
			mux_en    <= 1'b0;
			send_data <= 1'b0;
			canale    <= '0;
		end else begin
			case (state)
				acq_idle: begin
					// enable the mux on the current channel
					mux_en <= 1'b1;
					state  <= acq_select;
				end
				acq_select: begin
					// one cycle for the mux to settle
					state <= acq_start_conv;
				end
				acq_start_conv: begin
					soc   <= 1'b1;
					state <= acq_wait_eoc;
				end
				acq_wait_eoc: begin
					if (eoc) begin
						// data_in is valid with eoc
						load_dato <= 1'b1;
						mux_en    <= 1'b0;
						state     <= acq_wait_release;
					end
				end
				acq_wait_release: begin
					// load_dato lasts one cycle, soc drops with it
					load_dato <= 1'b0;
					soc       <= 1'b0;
					// converter must drop eoc before the next phase
					if (!soc && !eoc) begin
						state <= acq_request;
					end
				end
				acq_request: begin
					// previous rdy must be gone first
					if (!rdy) begin
						send_data <= 1'b1;
						state     <= acq_wait_ack;
					end
				end
				acq_wait_ack: begin
					if (rdy) begin
						send_data <= 1'b0;
						// next channel, wraps after the last input
						if (canale == chan_t'(NUM_CHANNELS - 1)) begin
							canale <= '0;
						end else begin
							canale <= chan_t'(canale + 1'b1);
						end
						state <= acq_idle;
					end
				end
				default: begin
					state <= acq_idle;
				end
			endcase
		end
	end

	// capture strobe only inside an open conversion
	assert property (@(posedge clock) disable iff (rst) load_dato |-> soc);

endmodule

/* rtl/frame_scheduler.sv */
// frame scheduler
// turns each sample into a header frame and a data frame
// and requests them from the link controller over shot/confirm
`timescale 1ns/100ps

module frame_scheduler import telemetry_pkg::*; (
	input  logic       clock,
	input  logic       rst,
	input  logic       send_data,
	output logic       rdy,
	input  logic [7:0] sample,
	input  chan_t      canale,
	output logic       shot,
	input  logic       confirm,
	output logic [7:0] frame_byte,
	output logic       add_mpx2
);

	sched_state_t state;

	// frame byte, held stable while shot is high
	always_ff @(posedge clock) begin
		if (state == sched_header) begin
			frame_byte <= {HDR_MARK, 1'b0, canale};
		end else if (state == sched_data && !confirm) begin
			frame_byte <= sample;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			state    <= sched_idle;
			rdy      <= 1'b0;
			shot     <= 1'b0;
			add_mpx2 <= 1'b0;
		end else begin
			case (state)
				sched_idle: begin
					if (send_data) begin
						state <= sched_header;
					end
				end
				sched_header: begin
					shot  <= 1'b1;
					state <= sched_wait_header;
				end
				sched_wait_header: begin
					if (confirm) begin
						shot  <= 1'b0;
						state <= sched_data;
					end
				end
				sched_data: begin
					// wait for the header confirm to fall
					if (!confirm) begin
						shot     <= 1'b1;
						add_mpx2 <= 1'b1;
						state    <= sched_wait_data;
					end
				end
				sched_wait_data: begin
					// both frames sent
					if (confirm) begin
						shot     <= 1'b0;
						add_mpx2 <= 1'b0;
						rdy      <= 1'b1;
						state    <= sched_release;
					end
				end
				sched_release: begin
					// close both handshakes before the next sample
					if (!send_data && !confirm) begin
						rdy   <= 1'b0;
						state <= sched_idle;
					end
				end
				default: begin
					state <= sched_idle;
				end
			endcase
		end
	end

	// data frame marker never overlaps the sample acknowledge
	assert property (@(posedge clock) disable iff (rst) add_mpx2 |-> !rdy);

endmodule

/* rtl/link_controller.sv */
// link controller
// loads each requested frame into the data path, starts it
// and confirms to the scheduler once the stop bit is out
`timescale 1ns/100ps

module link_controller import telemetry_pkg::*; (
	input  logic       clock,
	input  logic       rst,
	input  logic       shot,
	input  logic [7:0] frame_byte,
	output logic       confirm,
	tx_ctrl_if.ctrl    tx
);

	link_state_t state;

	// strobes decoded from the state
	assign tx.load       = (state == link_load);
	// send held off while the receiver withholds dsr
	assign tx.send       = (state == link_send) && !tx.error;
	assign tx.frame_byte = frame_byte;

	always_ff @(posedge clock) begin
		if (rst) begin
			state   <= link_idle;
			confirm <= 1'b0;
		end else begin
			case (state)
				link_idle: begin
					if (confirm) begin
						// confirm falls only after shot has fallen
						if (!shot) begin
							confirm <= 1'b0;
						end
					end else if (shot && !tx.busy) begin
						state <= link_load;
					end
				end
				link_load: begin
					state <= link_send;
				end
				link_send: begin
					if (!tx.error) begin
						state <= link_wait_end;
					end
				end
				link_wait_end: begin
					if (tx.tx_end) begin
						confirm <= 1'b1;
						state   <= link_idle;
					end
				end
			endcase
		end
	end

	assert property (@(posedge clock) disable iff (rst) !(tx.load && tx.send));

endmodule

/* rtl/bit_timer.sv */
// baud counter
// one tick on the last clock of every bit period while run is high
`timescale 1ns/100ps

module bit_timer import serial_pkg::*; (
	input  logic clock,
	input  logic rst,
	input  logic run,
	output logic tick
);

	logic [BIT_CNT_W-1:0] cnt;

	assign tick = run && (cnt == BIT_CNT_W'(BIT_CYCLES - 1));

	always_ff @(posedge clock) begin
		if (rst || !run) begin
			// restart the bit period for each new frame
			cnt <= '0;
		end else if (tick) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

/* rtl/uart_tx_path.sv */
// transmit data path
// output register, register full flag, dsr check and error flag
// bit slot shifter driving data_out, msb first, one start and one stop bit
`timescale 1ns/100ps

module uart_tx_path import serial_pkg::*; (
	input  logic    clock,
	input  logic    rst,
	input  logic    dsr,
	input  logic    tick,
	tx_ctrl_if.path tx,
	output logic    run,
	output logic    data_out
);

	logic [7:0] out_reg;
	// transmit register full
	logic       tre;
	// frame released by send
	logic       send_en;
	// frame on the line
	logic       active;
	logic       tx_end;
	logic       error;
	bit_slot_t  slot;

	assign run       = tre;
	assign tx.busy   = tre;
	assign tx.tx_end = tx_end;
	assign tx.error  = error;

	// output register doubles as the shifter
	always_ff @(posedge clock) begin
		if (tx.load && !tre) begin
			out_reg <= tx.frame_byte;
		end else if (tick && active && slot != slot_bit0 && slot != slot_stop) begin
			out_reg <= {out_reg[6:0], 1'b0};
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			tre      <= 1'b0;
			send_en  <= 1'b0;
			active   <= 1'b0;
			tx_end   <= 1'b0;
			error    <= 1'b0;
			slot     <= slot_start;
			data_out <= 1'b1;
		end else begin
			tx_end <= 1'b0;
			// frame pending and receiver not ready
			error  <= (tre || tx.load) && !active && !dsr;
			if (tx.load && !tre) begin
				tre <= 1'b1;
			end
			if (tx.send && tre) begin
				send_en <= 1'b1;
			end
			if (tick) begin
				if (!active) begin
					// start bit only once dsr is back
					if (send_en && dsr) begin
						active   <= 1'b1;
						slot     <= slot_start;
						data_out <= 1'b0;
					end
				end else begin
					case (slot)
						slot_stop: begin
							// stop bit done, frame complete
							active  <= 1'b0;
							send_en <= 1'b0;
							tre     <= 1'b0;
							tx_end  <= 1'b1;
							slot    <= slot_start;
						end
						slot_bit0: begin
							data_out <= 1'b1;
							slot     <= slot_stop;
						end
						default: begin
							data_out <= out_reg[7];
							slot     <= bit_slot_t'(slot + 1'b1);
						end
					endcase
				end
			end
		end
	end

	// an error is only ever reported with a frame held in the register
	assert property (@(posedge clock) disable iff (rst) error |-> tre);

endmodule

/* rtl/weather_tx_top.sv */
// weather station telemetry transmitter top level
// converter sequencer, frame scheduler, link controller and serial path
`timescale 1ns/100ps

module weather_tx_top import telemetry_pkg::*; (
	input  logic       clock,
	input  logic       rst,
	input  logic       eoc,
	input  logic [7:0] data_in,
	input  logic       dsr,
	output logic       soc,
	output logic       load_dato,
	output logic       mux_en,
	output chan_t      canale,
	output logic       add_mpx2,
	output logic       error,
	output logic       data_out
);

	// sample hand-off
	logic       send_data;
	logic       rdy;
	logic [7:0] sample;
	// frame request
	logic       shot;
	logic       confirm;
	logic [7:0] frame_byte;
	// bit timing
	logic       run;
	logic       tick;

	tx_ctrl_if tx_bus ();

	assign error = tx_bus.error;

	acq_sequencer seq0 (
		.clock     (clock),
		.rst       (rst),
		.eoc       (eoc),
		.data_in   (data_in),
		.soc       (soc),
		.load_dato (load_dato),
		.mux_en    (mux_en),
		.canale    (canale),
		.send_data (send_data),
		.rdy       (rdy),
		.sample    (sample)
	);

	frame_scheduler sched0 (
		.clock      (clock),
		.rst        (rst),
		.send_data  (send_data),
		.rdy        (rdy),
		.sample     (sample),
		.canale     (canale),
		.shot       (shot),
		.confirm    (confirm),
		.frame_byte (frame_byte),
		.add_mpx2   (add_mpx2)
	);

	link_controller link0 (
		.clock      (clock),
		.rst        (rst),
		.shot       (shot),
		.frame_byte (frame_byte),
		.confirm    (confirm),
		.tx         (tx_bus.ctrl)
	);

	bit_timer timer0 (
		.clock (clock),
		.rst   (rst),
		.run   (run),
		.tick  (tick)
	);

	uart_tx_path path0 (
		.clock    (clock),
		.rst      (rst),
		.dsr      (dsr),
		.tick     (tick),
		.tx       (tx_bus.path),
		.run      (run),
		.data_out (data_out)
	);

endmodule

/* bench/tb_checks.svh */
// compare tasks for bytes, channels and single-bit outputs
// expected frame queue and the header byte rule
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// frames still to appear on data_out, oldest first
logic [7:0] exp_q[$];

// header byte is the mark nibble, a zero bit and the channel
function automatic logic [7:0] header_byte(input chan_t chan);
	return {HDR_MARK, 1'b0, chan};
endfunction

// each sample gives a header frame, then a frame with the data byte
function automatic void push_sample(input chan_t chan, input logic [7:0] value);
	exp_q.push_back(header_byte(chan));
	exp_q.push_back(value);
endfunction

// single-bit outputs and line levels
task automatic check_bit(input string name, input logic got, input logic want);
	if (got !== want) begin
		fail_run($sformatf("Fail at %0t ns: %s got %b expected %b",
			$time, name, got, want));
	end
endtask

// decoded frame bytes
task automatic check_byte(input string name, input logic [7:0] got,
		input logic [7:0] want);
	if (got !== want) begin
		fail_run($sformatf("Fail at %0t ns: %s got %h expected %h",
			$time, name, got, want));
	end
endtask

// mux channel number
task automatic check_chan(input string name, input chan_t got, input chan_t want);
	if (got !== want) begin
		fail_run($sformatf("Fail at %0t ns: %s got %0d expected %0d",
			$time, name, got, want));
	end
endtask

`endif

/* bench/tb_weather_tx.sv */
// testbench for the weather telemetry transmitter
// clock and reset, converter model, random dsr stalls,
// serial decoder with per-cycle line checks, watchdog
`timescale 1ns/100ps

module tb_weather_tx import telemetry_pkg::*, serial_pkg::*; ();

	localparam int          CLK_PERIOD   = 8;
	localparam int          RESET_CYCLES = 16;
	localparam int          NUM_SAMPLES  = 24;
	localparam int unsigned SEED         = 32'h3d885c1e;
	// idle line this long with a frame waiting means the frame sits in the path
	localparam int          PEND_SETTLE  = 24;
	// eoc hold that outlasts both frames of a sample and their dsr stalls
	localparam int          LONG_HOLD    = 4 * FRAME_BITS * BIT_CYCLES;
	localparam int          WATCHDOG_CYCLES =
		NUM_SAMPLES * 2 * FRAME_BITS * BIT_CYCLES * 4 + RESET_CYCLES;

	logic       clock;
	logic       rst;
	logic       eoc;
	logic [7:0] data_in;
	logic       dsr;
	logic       soc;
	logic       load_dato;
	logic       mux_en;
	chan_t      canale;
	logic       add_mpx2;
	logic       error;
	logic       data_out;

	// dsr and eoc as the DUT saw them at the last rising edge
	logic       dsr_q;
	logic       eoc_q;
	int         frames_done;

	weather_tx_top dut0 (
		.clock     (clock),
		.rst       (rst),
		.eoc       (eoc),
		.data_in   (data_in),
		.dsr       (dsr),
		.soc       (soc),
		.load_dato (load_dato),
		.mux_en    (mux_en),
		.canale    (canale),
		.add_mpx2  (add_mpx2),
		.error     (error),
		.data_out  (data_out)
	);

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	`include "tb_checks.svh"

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	always @(posedge clock) begin
		dsr_q <= dsr;
		eoc_q <= eoc;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		fail_run($sformatf("watchdog expired after %0d cycles with %0d of %0d frames",
			WATCHDOG_CYCLES, frames_done, 2 * NUM_SAMPLES));
	end

	task automatic check_reset_state();
		check_bit("data_out", data_out, 1'b1);
		check_bit("soc", soc, 1'b0);
		check_bit("mux_en", mux_en, 1'b0);
		check_bit("load_dato", load_dato, 1'b0);
		check_bit("add_mpx2", add_mpx2, 1'b0);
		check_bit("error", error, 1'b0);
		check_chan("canale", canale, '0);
	endtask

	// converter side of the soc/eoc four-phase handshake
	task automatic run_converter();
		chan_t      chan;
		logic [7:0] value;
		int         wait_len;
		int         pulses;
		chan = '0;
		forever begin
			@(negedge clock);
			while (!soc) @(negedge clock);
			// channel steps once per sample and wraps
			check_chan("canale", canale, chan);
			check_bit("mux_en", mux_en, 1'b1);
			wait_len = $urandom_range(12, 0);
			repeat (wait_len) @(negedge clock);
			value   = 8'($urandom);
			data_in = value;
			eoc     = 1'b1;
			push_sample(chan, value);
			// count capture strobes until soc drops
			pulses = 0;
			@(negedge clock);
			while (soc) begin
				if (load_dato) begin
					pulses++;
				end
				@(negedge clock);
			end
			if (pulses != 1) begin
				fail_run($sformatf("load_dato pulsed %0d times in one conversion", pulses));
			end else begin
				// stale data after the capture
				data_in = 8'($urandom);
				// every fourth sample keeps eoc up longer than a whole hand-off
				if (chan[1:0] == 2'd3) begin
					wait_len = LONG_HOLD;
				end else begin
					wait_len = $urandom_range(12, 0);
				end
				repeat (wait_len) begin
					@(negedge clock);
					// no new conversion while eoc is still up
					check_bit("soc", soc, 1'b0);
				end
				eoc  = 1'b0;
				chan = chan_t'((int'(chan) + 1) % NUM_CHANNELS);
			end
		end
	endtask

	// receiver readiness in random high and low stretches
	task automatic drive_dsr();
		int high_len;
		int low_len;
		forever begin
			high_len = $urandom_range(400, 80);
			low_len  = $urandom_range(200, 10);
			dsr = 1'b1;
			repeat (high_len) @(negedge clock);
			dsr = 1'b0;
			repeat (low_len) @(negedge clock);
		end
	endtask

	// finds start bits, checks every cycle of the frame, decodes at bit centres
	task automatic decode_frames();
		logic       prev_line;
		logic       is_data;
		logic       level;
		logic       center;
		logic [7:0] got;
		logic [7:0] want;
		int         age;
		int         b;
		int         k;
		prev_line = 1'b1;
		age       = 0;
		got       = '0;
		while (frames_done < 2 * NUM_SAMPLES) begin
			@(negedge clock);
			if (prev_line && !data_out) begin
				check_bit("dsr at start bit", dsr_q, 1'b1);
				if (exp_q.size() == 0) begin
					fail_run("start bit on data_out with no frame expected");
				end else begin
					want    = exp_q.pop_front();
					// header frames are even, data frames odd
					is_data = (frames_done % 2) == 1;
					for (b = 0; b < FRAME_BITS; b++) begin
						for (k = 0; k < BIT_CYCLES; k++) begin
							if (b > 0 || k > 0) @(negedge clock);
							// level must hold for the whole bit period
							if (k == 0) level = data_out;
							if (k == BIT_CYCLES / 2) center = data_out;
							check_bit("data_out", data_out, level);
							check_bit("add_mpx2", add_mpx2, is_data);
							check_bit("error", error, 1'b0);
						end
						if (b == 0) begin
							check_bit("start bit", center, 1'b0);
						end else if (b == FRAME_BITS - 1) begin
							check_bit("stop bit", center, 1'b1);
						end else begin
							got = {got[6:0], center};
						end
					end
					check_byte("frame byte", got, want);
					frames_done++;
					prev_line = 1'b1;
					age       = 0;
				end
			end else begin
				prev_line = data_out;
				// frame waiting since the converter released eoc or the last frame ended
				if (exp_q.size() == 0 || eoc_q) begin
					age = 0;
				end else begin
					age++;
				end
				if (dsr_q) begin
					check_bit("error", error, 1'b0);
				end else if (age > PEND_SETTLE) begin
					check_bit("error", error, 1'b1);
				end
			end
		end
	endtask

	initial begin
		void'($urandom(SEED));
		rst         = 1'b1;
		eoc         = 1'b0;
		data_in     = '0;
		dsr         = 1'b1;
		frames_done = 0;
		repeat (RESET_CYCLES) @(negedge clock);
		check_reset_state();
		rst = 1'b0;
		fork
			run_converter();
			drive_dsr();
		join_none
		decode_frames();
		if (frames_done == 2 * NUM_SAMPLES) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			fail_run("decoder stopped before all frames were seen");
		end
	end

endmodule

/* flist.f */
+incdir+bench
rtl/telemetry_pkg.sv
rtl/serial_pkg.sv
rtl/tx_ctrl_if.sv
rtl/acq_sequencer.sv
rtl/frame_scheduler.sv
rtl/link_controller.sv
rtl/bit_timer.sv
rtl/uart_tx_path.sv
rtl/weather_tx_top.sv
bench/tb_weather_tx.sv

/* run.sh */
#!/bin/sh
# builds the weather telemetry testbench with Verilator and runs it
# the exit status of the simulation is the pass or fail result
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_weather_tx \
	-f flist.f \
	--Mdir obj_dir \
	-o tb_weather_tx

./obj_dir/tb_weather_tx
